/* isaPkg.sv */
package isaPkg;

	localparam int dataWidth = 16;
	localparam int operandWidth = 12;

	typedef logic [dataWidth-1:0] word;

	// Major opcode in ir[15:12]
	// Unlisted values execute as no-ops
	typedef enum logic [3:0] {
		LDm = 4'd0,
		LDa = 4'd1,
		LDn = 4'd2,
		STa = 4'd3,
		STn = 4'd4,
		ANa = 4'd7,
		ADm = 4'd8,
		ADa = 4'd9,
		ADn = 4'd10,
		MLa = 4'd11,
		JMa = 4'd12,
		JMn = 4'd13,
		EXT = 4'd15
	} opcode;

	// Sub-operation of EXT in ir[11:8]
	typedef enum logic [3:0] {
		GROUP2 = 4'd1,
		SRA = 4'd2,
		SLL = 4'd3,
		SRL = 4'd4,
		SKP = 4'd9
	} extOp;

	// Accumulator group in ir[7:5]
	typedef enum logic [2:0] {
		ACZ = 3'd2,
		ACN = 3'd3,
		ACI = 3'd4
	} group2Op;

	// Positions inside the flag vector
	localparam int flagZ = 3;
	localparam int flagN = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

endpackage

/* ctrlPkg.sv */
package ctrlPkg;

	typedef enum logic [1:0] {
		FETCH,
		EXEC1,
		EXEC2
	} cpuState;

	// Accumulator load source
	typedef enum logic [1:0] {
		AC_IMM,
		AC_MEM,
		AC_ALU,
		AC_ZERO
	} acSrc;

	typedef enum logic [1:0] {
		PC_INC,
		PC_MEM,
		PC_IMM
	} pcSrc;

	// Memory address source
	typedef enum logic [1:0] {
		ADDR_PC,
		ADDR_IMM,
		ADDR_IN
	} addrSrc;

	typedef enum logic [2:0] {
		OP_AND,
		OP_NOT,
		OP_ADD,
		OP_INC,
		OP_MUL,
		OP_SRA,
		OP_SRL,
		OP_SLL
	} aluOp;

	// Second ALU input
	typedef enum logic {
		OPND_IMM,
		OPND_MEM
	} aluOperand;

endpackage

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input isaPkg::word acc,
	input isaPkg::word operand,
	input ctrlPkg::aluOp op,
	output isaPkg::word result,
	output logic [3:0] flags
);

	isaPkg::word addend;
	logic [isaPkg::dataWidth:0] sum;
	logic [3:0] shamt;

	// Increment shares the adder with a constant one
	assign addend = (op == ctrlPkg::OP_INC) ? 16'd1 : operand;
	assign sum = {1'b0, acc} + {1'b0, addend};
	assign shamt = operand[3:0];

	always_comb
	begin
		result = '0;
		case (op)
			ctrlPkg::OP_AND:
				result = acc & operand;
			ctrlPkg::OP_NOT:
				result = ~acc;
			ctrlPkg::OP_ADD, ctrlPkg::OP_INC:
				result = sum[isaPkg::dataWidth-1:0];
			ctrlPkg::OP_MUL:
				result = acc[7:0] * operand[7:0];
			ctrlPkg::OP_SRA:
				result = $signed(acc) >>> shamt;
			ctrlPkg::OP_SRL:
				result = acc >> shamt;
			ctrlPkg::OP_SLL:
				result = acc << shamt;
			default:
				result = '0;
		endcase
	end

	always_comb
	begin
		flags = 4'b0;
		flags[isaPkg::flagZ] = (result == '0);
		flags[isaPkg::flagN] = result[isaPkg::dataWidth-1];
		flags[isaPkg::flagC] = sum[isaPkg::dataWidth];
		// Same-sign addends with a sum of the other sign
		flags[isaPkg::flagV] = (acc[isaPkg::dataWidth-1] == addend[isaPkg::dataWidth-1])
			&& (sum[isaPkg::dataWidth-1] != acc[isaPkg::dataWidth-1]);
	end

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input logic clk,
	input logic rst,
	input isaPkg::word ir,
	input logic skipHit,
	output ctrlPkg::acSrc accSel,
	output ctrlPkg::pcSrc pcSel,
	output ctrlPkg::addrSrc addrSel,
	output ctrlPkg::aluOperand opnd,
	output ctrlPkg::aluOp op,
	output logic ldIr,
	output logic ldAc,
	output logic ldPc,
	output logic ldIn,
	output logic pcStep2,
	output logic readMem,
	output logic writeMem,
	output logic [3:0] ldFlags
);

	ctrlPkg::cpuState state;
	ctrlPkg::cpuState nextState;

	isaPkg::opcode opc;
	isaPkg::extOp ext;
	isaPkg::group2Op grp;

	assign opc = isaPkg::opcode'(ir[15:12]);
	assign ext = isaPkg::extOp'(ir[11:8]);
	assign grp = isaPkg::group2Op'(ir[7:5]);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= ctrlPkg::FETCH;
		else
			state <= nextState;
	end

	always_comb
	begin
		accSel = ctrlPkg::AC_ALU;
		pcSel = ctrlPkg::PC_INC;
		addrSel = ctrlPkg::ADDR_PC;
		opnd = ctrlPkg::OPND_MEM;
		op = ctrlPkg::OP_ADD;
		ldIr = 1'b0;
		ldAc = 1'b0;
		ldPc = 1'b0;
		ldIn = 1'b0;
		pcStep2 = 1'b0;
		readMem = 1'b0;
		writeMem = 1'b0;
		ldFlags = 4'b0;
		nextState = ctrlPkg::FETCH;

		case (state)
			ctrlPkg::FETCH:
			begin
				readMem = 1'b1;
				ldIr = 1'b1;
				nextState = ctrlPkg::EXEC1;
			end
			ctrlPkg::EXEC1:
			begin
				// Most instructions finish here and step the PC
				ldPc = 1'b1;
				case (opc)
					isaPkg::LDm:
					begin
						accSel = ctrlPkg::AC_IMM;
						ldAc = 1'b1;
					end
					isaPkg::LDa:
					begin
						addrSel = ctrlPkg::ADDR_IMM;
						readMem = 1'b1;
						accSel = ctrlPkg::AC_MEM;
						ldAc = 1'b1;
					end
					isaPkg::LDn, isaPkg::STn, isaPkg::ADn:
					begin
						// Fetch the pointer, finish in EXEC2
						addrSel = ctrlPkg::ADDR_IMM;
						readMem = 1'b1;
						ldIn = 1'b1;
						ldPc = 1'b0;
						nextState = ctrlPkg::EXEC2;
					end
					isaPkg::STa:
					begin
						addrSel = ctrlPkg::ADDR_IMM;
						writeMem = 1'b1;
					end
					isaPkg::ANa:
					begin
						addrSel = ctrlPkg::ADDR_IMM;
						readMem = 1'b1;
						op = ctrlPkg::OP_AND;
						ldAc = 1'b1;
						ldFlags[isaPkg::flagZ] = 1'b1;
						ldFlags[isaPkg::flagN] = 1'b1;
					end
					isaPkg::ADm:
					begin
						opnd = ctrlPkg::OPND_IMM;
						ldAc = 1'b1;
						ldFlags = 4'b1111;
					end
					isaPkg::ADa:
					begin
						addrSel = ctrlPkg::ADDR_IMM;
						readMem = 1'b1;
						ldAc = 1'b1;
						ldFlags = 4'b1111;
					end
					isaPkg::MLa:
					begin
						addrSel = ctrlPkg::ADDR_IMM;
						readMem = 1'b1;
						op = ctrlPkg::OP_MUL;
						ldAc = 1'b1;
						ldFlags[isaPkg::flagZ] = 1'b1;
					end
					isaPkg::JMa:
						pcSel = ctrlPkg::PC_IMM;
					isaPkg::JMn:
					begin
						addrSel = ctrlPkg::ADDR_IMM;
						readMem = 1'b1;
						pcSel = ctrlPkg::PC_MEM;
					end
					isaPkg::EXT:
					begin
						case (ext)
							isaPkg::GROUP2:
							begin
								case (grp)
									isaPkg::ACZ:
									begin
										accSel = ctrlPkg::AC_ZERO;
										ldAc = 1'b1;
										ldFlags[isaPkg::flagZ] = 1'b1;
										ldFlags[isaPkg::flagN] = 1'b1;
									end
									isaPkg::ACN:
									begin
										op = ctrlPkg::OP_NOT;
										ldAc = 1'b1;
										ldFlags[isaPkg::flagZ] = 1'b1;
										ldFlags[isaPkg::flagN] = 1'b1;
									end
									isaPkg::ACI:
									begin
										op = ctrlPkg::OP_INC;
										ldAc = 1'b1;
									end
									default:
									begin
									end
								endcase
							end
							isaPkg::SRA, isaPkg::SRL, isaPkg::SLL:
							begin
								opnd = ctrlPkg::OPND_IMM;
								ldAc = 1'b1;
								if (ext == isaPkg::SRA)
									op = ctrlPkg::OP_SRA;
								else if (ext == isaPkg::SRL)
									op = ctrlPkg::OP_SRL;
								else
									op = ctrlPkg::OP_SLL;
							end
							isaPkg::SKP:
								pcStep2 = skipHit;
							default:
							begin
							end
						endcase
					end
					default:
					begin
					end
				endcase
			end
			ctrlPkg::EXEC2:
			begin
				ldPc = 1'b1;
				addrSel = ctrlPkg::ADDR_IN;
				case (opc)
					isaPkg::LDn:
					begin
						readMem = 1'b1;
						accSel = ctrlPkg::AC_MEM;
						ldAc = 1'b1;
					end
					isaPkg::STn:
						writeMem = 1'b1;
					isaPkg::ADn:
					begin
						readMem = 1'b1;
						ldAc = 1'b1;
						ldFlags = 4'b1111;
					end
					default:
					begin
					end
				endcase
			end
			default:
				nextState = ctrlPkg::FETCH;
		endcase
	end

	strobeExclusive: assert property (@(posedge clk) disable iff (rst)
		!(readMem && writeMem));

	stateLegal: assert property (@(posedge clk) disable iff (rst)
		state inside {ctrlPkg::FETCH, ctrlPkg::EXEC1, ctrlPkg::EXEC2});

endmodule

/* datapath.sv */
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic rst,
	input isaPkg::word dataIn,
	input ctrlPkg::acSrc accSel,
	input ctrlPkg::pcSrc pcSel,
	input ctrlPkg::addrSrc addrSel,
	input ctrlPkg::aluOperand opnd,
	input ctrlPkg::aluOp op,
	input logic ldIr,
	input logic ldAc,
	input logic ldPc,
	input logic ldIn,
	input logic [3:0] ldFlags,
	input logic pcStep2,
	output isaPkg::word dataOut,
	output isaPkg::word addr,
	output isaPkg::word ir,
	output logic skipHit
);

	localparam int extBits = isaPkg::dataWidth - isaPkg::operandWidth;

	isaPkg::word pc;
	isaPkg::word acc;
	isaPkg::word inPtr;
	isaPkg::word irReg;
	logic [3:0] flagReg;

	isaPkg::word immSext;
	isaPkg::word immZext;
	isaPkg::word pcInc;
	isaPkg::word accNext;
	isaPkg::word pcNext;
	isaPkg::word aluIn;
	isaPkg::word aluResult;
	logic [3:0] aluFlags;
	logic [3:0] flagNext;

	assign immSext = {{extBits{irReg[isaPkg::operandWidth-1]}},
		irReg[isaPkg::operandWidth-1:0]};
	assign immZext = {{extBits{1'b0}}, irReg[isaPkg::operandWidth-1:0]};
	assign pcInc = pc + (pcStep2 ? 16'd2 : 16'd1);

	// Stores only ever write the accumulator
	assign dataOut = acc;
	assign ir = irReg;

	// Observe mask in ir[7:4], expected values in ir[3:0]
	assign skipHit = |(irReg[7:4] & ~(flagReg ^ irReg[3:0]));

	assign aluIn = (opnd == ctrlPkg::OPND_IMM) ? immSext : dataIn;

	always_comb
	begin
		case (addrSel)
			ctrlPkg::ADDR_IMM: addr = immZext;
			ctrlPkg::ADDR_IN: addr = inPtr;
			default: addr = pc;
		endcase

		case (accSel)
			ctrlPkg::AC_IMM: accNext = immSext;
			ctrlPkg::AC_MEM: accNext = dataIn;
			ctrlPkg::AC_ALU: accNext = aluResult;
			default: accNext = '0;
		endcase

		case (pcSel)
			ctrlPkg::PC_MEM: pcNext = dataIn;
			ctrlPkg::PC_IMM: pcNext = immZext;
			default: pcNext = pcInc;
		endcase

		// Clearing the accumulator sets Z and clears the rest
		flagNext = aluFlags;
		if (accSel == ctrlPkg::AC_ZERO)
		begin
			flagNext = 4'b0;
			flagNext[isaPkg::flagZ] = 1'b1;
		end
	end

	alu aluUnit (
		.acc(acc),
		.operand(aluIn),
		.op(op),
		.result(aluResult),
		.flags(aluFlags)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pc <= '0;
			acc <= '0;
			inPtr <= '0;
			irReg <= '0;
			flagReg <= 4'b0;
		end
		else
		begin
			if (ldPc)
				pc <= pcNext;
			if (ldAc)
				acc <= accNext;
			if (ldIn)
				inPtr <= dataIn;
			if (ldIr)
				irReg <= dataIn;
			for (int i = 0; i < 4; i++)
			begin
				if (ldFlags[i])
					flagReg[i] <= flagNext[i];
			end
		end
	end

	flagSource: assert property (@(posedge clk) disable iff (rst)
		(ldFlags != 4'b0) |-> (accSel == ctrlPkg::AC_ALU || accSel == ctrlPkg::AC_ZERO));

endmodule

/* punehTop.sv */
`timescale 1ns/1ps

module punehTop (
	input logic clk,
	input logic rst,
	input isaPkg::word dataIn,
	output isaPkg::word dataOut,
	output isaPkg::word addr,
	output logic readMem,
	output logic writeMem
);

	isaPkg::word ir;
	logic skipHit;

	ctrlPkg::acSrc accSel;
	ctrlPkg::pcSrc pcSel;
	ctrlPkg::addrSrc addrSel;
	ctrlPkg::aluOperand opnd;
	ctrlPkg::aluOp op;

	logic ldIr;
	logic ldAc;
	logic ldPc;
	logic ldIn;
	logic pcStep2;
	logic [3:0] ldFlags;

	controlUnit cu (
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.skipHit(skipHit),
		.accSel(accSel),
		.pcSel(pcSel),
		.addrSel(addrSel),
		.opnd(opnd),
		.op(op),
		.ldIr(ldIr),
		.ldAc(ldAc),
		.ldPc(ldPc),
		.ldIn(ldIn),
		.pcStep2(pcStep2),
		.readMem(readMem),
		.writeMem(writeMem),
		.ldFlags(ldFlags)
	);

	datapath dp (
		.clk(clk),
		.rst(rst),
		.dataIn(dataIn),
		.accSel(accSel),
		.pcSel(pcSel),
		.addrSel(addrSel),
		.opnd(opnd),
		.op(op),
		.ldIr(ldIr),
		.ldAc(ldAc),
		.ldPc(ldPc),
		.ldIn(ldIn),
		.ldFlags(ldFlags),
		.pcStep2(pcStep2),
		.dataOut(dataOut),
		.addr(addr),
		.ir(ir),
		.skipHit(skipHit)
	);

endmodule

/* tbChecker.sv */
`timescale 1ns/1ps

module tbChecker (
	input logic clk,
	input logic rst,
	input isaPkg::word addr,
	input isaPkg::word dataOut,
	input logic readMem,
	input logic writeMem,
	input isaPkg::word image [0:4095],
	input logic testActive,
	input int testId,
	output int testsRun,
	output int testsFailed,
	output int errorCount
);

	isaPkg::word refMem [0:4095];
	isaPkg::word expAddr [$];
	isaPkg::word expData [$];
	isaPkg::word wantAddr;
	isaPkg::word wantData;
	int runCount = 0;
	int failCount = 0;
	int errCount = 0;
	int testErrors = 0;
	int storeCount = 0;
	logic sawFetch = 1'b0;
	logic activeQ = 1'b0;

	assign testsRun = runCount;
	assign testsFailed = failCount;
	assign errorCount = errCount;

	// Executes refMem from address 0 and queues every store up to the self-jump
	function automatic void predictStores();
		isaPkg::word pc;
		isaPkg::word acc;
		isaPkg::word inst;
		isaPkg::word imm;
		isaPkg::word dir;
		isaPkg::word ind;
		isaPkg::word nextPc;
		logic [16:0] sum;
		logic [31:0] wide;
		logic [3:0] fl;
		logic hit;
		pc = '0;
		acc = '0;
		fl = 4'b0;
		expAddr.delete();
		expData.delete();
		for (int step = 0; step < 2000; step++)
		begin
			inst = refMem[pc[11:0]];
			imm = {{4{inst[11]}}, inst[11:0]};
			dir = refMem[inst[11:0]];
			ind = refMem[dir[11:0]];
			nextPc = pc + 16'd1;
			case (inst[15:12])
				isaPkg::LDm:
					acc = imm;
				isaPkg::LDa:
					acc = dir;
				isaPkg::LDn:
					acc = ind;
				isaPkg::STa, isaPkg::STn:
				begin
					// STn writes through the pointer it names
					if (inst[15:12] == isaPkg::STa)
						dir = {4'h0, inst[11:0]};
					refMem[dir[11:0]] = acc;
					expAddr.push_back(dir);
					expData.push_back(acc);
				end
				isaPkg::ANa:
				begin
					acc = acc & dir;
					fl[isaPkg::flagZ] = (acc == 16'h0);
					fl[isaPkg::flagN] = acc[15];
				end
				isaPkg::ADm, isaPkg::ADa, isaPkg::ADn:
				begin
					if (inst[15:12] == isaPkg::ADm)
						ind = imm;
					else if (inst[15:12] == isaPkg::ADa)
						ind = dir;
					sum = {1'b0, acc} + {1'b0, ind};
					fl[isaPkg::flagV] = (acc[15] == ind[15]) && (sum[15] != ind[15]);
					fl[isaPkg::flagC] = sum[16];
					acc = sum[15:0];
					fl[isaPkg::flagZ] = (acc == 16'h0);
					fl[isaPkg::flagN] = acc[15];
				end
				isaPkg::MLa:
				begin
					acc = {8'h0, acc[7:0]} * {8'h0, dir[7:0]};
					fl[isaPkg::flagZ] = (acc == 16'h0);
				end
				isaPkg::JMa:
				begin
					if (inst[11:0] == pc[11:0])
						return;
					nextPc = {4'h0, inst[11:0]};
				end
				isaPkg::JMn:
					nextPc = dir;
				isaPkg::EXT:
				begin
					case (inst[11:8])
						isaPkg::GROUP2:
						begin
							if (inst[7:5] == isaPkg::ACZ)
							begin
								acc = 16'h0;
								fl[isaPkg::flagZ] = 1'b1;
								fl[isaPkg::flagN] = 1'b0;
							end
							else if (inst[7:5] == isaPkg::ACN)
							begin
								acc = ~acc;
								fl[isaPkg::flagZ] = (acc == 16'h0);
								fl[isaPkg::flagN] = acc[15];
							end
							else if (inst[7:5] == isaPkg::ACI)
								acc = acc + 16'd1;
						end
						isaPkg::SRA:
						begin
							wide = {{16{acc[15]}}, acc} >> inst[3:0];
							acc = wide[15:0];
						end
						isaPkg::SRL:
							acc = acc >> inst[3:0];
						isaPkg::SLL:
							acc = acc << inst[3:0];
						isaPkg::SKP:
						begin
							hit = 1'b0;
							for (int i = 0; i < 4; i++)
							begin
								if (inst[4 + i] && fl[i] == inst[i])
									hit = 1'b1;
							end
							if (hit)
								nextPc = pc + 16'd2;
						end
						default:
						begin
						end
					endcase
				end
				default:
				begin
				end
			endcase
			pc = nextPc;
		end
	endfunction

	task automatic noteFailure();
		testErrors++;
		errCount++;
	endtask

	task automatic startTest();
		for (int i = 0; i < 4096; i++)
			refMem[i] = image[i];
		predictStores();
		testErrors = 0;
		storeCount = 0;
		sawFetch = 1'b0;
	endtask

	task automatic finishTest();
		if (expAddr.size() != 0)
		begin
			$display("test %0d: %0d expected stores never happened", testId, expAddr.size());
			noteFailure();
		end
		runCount++;
		if (testErrors != 0)
			failCount++;
		$display("test %0d finished: %0d stores checked, %0s", testId, storeCount,
			(testErrors == 0) ? "ok" : "failed");
	endtask

	task automatic watchBus();
		if (!sawFetch)
		begin
			if (writeMem)
			begin
				$display("test %0d: a store happened before the first fetch", testId);
				noteFailure();
			end
			if (readMem)
			begin
				sawFetch = 1'b1;
				if (addr !== 16'h0)
				begin
					$display("error at %0t: test %0d first fetch read %h, expected 0000",
						$time, testId, addr);
					noteFailure();
				end
			end
		end
		else if (writeMem)
		begin
			if (expAddr.size() == 0)
			begin
				$display("test %0d: unexpected extra store of %h to address %h",
					testId, dataOut, addr);
				noteFailure();
			end
			else
			begin
				wantAddr = expAddr.pop_front();
				wantData = expData.pop_front();
				if (addr !== wantAddr || dataOut !== wantData)
				begin
					$display("error at %0t: test %0d store %0d wrote %h to %h, expected %h to %h",
						$time, testId, storeCount, dataOut, addr, wantData, wantAddr);
					noteFailure();
				end
				storeCount++;
			end
		end
	endtask

	// Bus values are stable at the rising edge
	always @(posedge clk)
	begin
		if (testActive && !activeQ)
			startTest();
		else if (!testActive && activeQ)
			finishTest();
		else if (testActive && !rst)
			watchBus();
		activeQ = testActive;
	end

endmodule

/* tbTop.sv */
`timescale 1ns/1ps

module tbTop;

	localparam int resetCycles = 8;
	localparam int maxProgLen = 96;
	localparam int testCount = 5;
	localparam int watchdogCycles = testCount * (resetCycles + maxProgLen * 3 + 12) + 50;

	logic clk;
	logic rst;
	isaPkg::word dataIn;
	isaPkg::word dataOut;
	isaPkg::word addr;
	logic readMem;
	logic writeMem;

	isaPkg::word mem [0:4095];
	isaPkg::word progImage [0:4095];
	logic testActive;
	int testId;
	int testsRun;
	int testsFailed;
	int errorCount;
	int seed;
	int progPc;
	isaPkg::word w;
	isaPkg::word p;

	punehTop uut (
		.clk(clk),
		.rst(rst),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.addr(addr),
		.readMem(readMem),
		.writeMem(writeMem)
	);

	tbChecker chk (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.dataOut(dataOut),
		.readMem(readMem),
		.writeMem(writeMem),
		.image(progImage),
		.testActive(testActive),
		.testId(testId),
		.testsRun(testsRun),
		.testsFailed(testsFailed),
		.errorCount(errorCount)
	);

	always #50 clk = ~clk;

	// Memory reloads its image while the DUT is in reset
	assign dataIn = mem[addr[11:0]];

	always @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < 4096; i++)
				mem[i] <= progImage[i];
		end
		else if (writeMem)
			mem[addr[11:0]] <= dataOut;
	end

	function automatic isaPkg::word instr(input logic [3:0] opc, input logic [11:0] arg);
		return {opc, arg};
	endfunction

	function automatic isaPkg::word extInstr(input logic [3:0] sub, input logic [7:0] low);
		return {isaPkg::EXT, sub, low};
	endfunction

	function automatic isaPkg::word randomWord();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// Unused words decode as no-ops and carry their own address
	task automatic startProgram();
		for (int i = 0; i < 4096; i++)
			progImage[i] = {4'h6, i[11:0]};
		progPc = 0;
	endtask

	task automatic put(input isaPkg::word inst);
		progImage[progPc] = inst;
		progPc++;
	endtask

	task automatic endProgram();
		put(instr(isaPkg::JMa, 12'(progPc)));
	endtask

	// Each flag that is clear lets one store through
	task automatic probeFlags(input logic [11:0] mark);
		for (int f = 0; f < 4; f++)
		begin
			put(extInstr(isaPkg::SKP, {4'(1 << f), 4'(1 << f)}));
			put(instr(isaPkg::STa, mark + 12'(f)));
		end
	endtask

	task automatic runTest(input int id);
		@(posedge clk);
		#1;
		testId = id;
		rst = 1'b1;
		testActive = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b0;
		repeat (progPc * 3 + 10) @(posedge clk);
		#1 testActive = 1'b0;
	endtask

	initial
	begin
		#(watchdogCycles * 100);
		$display("timeout: the tests did not finish in the expected time");
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		testActive = 1'b0;
		testId = 0;
		seed = 32'hd799a43a;

		// Direct loads and stores with negative and positive immediates
		startProgram();
		w = randomWord();
		put(instr(isaPkg::LDm, {1'b1, w[10:0]}));
		put(instr(isaPkg::STa, 12'h400));
		put(instr(isaPkg::LDm, {1'b0, w[14:4]}));
		put(instr(isaPkg::STa, 12'h401));
		progImage[12'h200] = randomWord();
		put(instr(isaPkg::LDa, 12'h200));
		put(instr(isaPkg::STa, 12'h402));
		endProgram();
		runTest(0);

		// Indirect access through random pointers
		startProgram();
		w = randomWord();
		p = {8'h03, w[7:0]};
		progImage[p[11:0]] = randomWord();
		progImage[12'h280] = p;
		w = randomWord();
		progImage[12'h281] = {8'h05, w[7:0]};
		progImage[12'h282] = {8'h06, w[15:8]};
		put(instr(isaPkg::LDn, 12'h280));
		put(instr(isaPkg::STn, 12'h281));
		put(instr(isaPkg::LDa, 12'h280));
		put(instr(isaPkg::STn, 12'h282));
		put(instr(isaPkg::LDn, 12'h281));
		put(instr(isaPkg::STa, 12'h403));
		endProgram();
		runTest(1);

		// Add and multiply flags
		startProgram();
		progImage[12'h220] = randomWord();
		progImage[12'h221] = 16'h7fff;
		progImage[12'h222] = randomWord();
		progImage[12'h223] = randomWord();
		progImage[12'h224] = randomWord();
		progImage[12'h290] = 16'h0223;
		w = randomWord();
		put(instr(isaPkg::LDm, w[11:0]));
		put(instr(isaPkg::ADm, w[15:4]));
		put(instr(isaPkg::STa, 12'h410));
		probeFlags(12'h420);
		put(instr(isaPkg::LDa, 12'h221));
		put(instr(isaPkg::ADm, 12'h001));
		put(instr(isaPkg::STa, 12'h411));
		probeFlags(12'h424);
		put(instr(isaPkg::LDa, 12'h220));
		put(instr(isaPkg::ADa, 12'h222));
		put(instr(isaPkg::STa, 12'h412));
		probeFlags(12'h428);
		put(instr(isaPkg::ADn, 12'h290));
		put(instr(isaPkg::STa, 12'h413));
		probeFlags(12'h42c);
		put(instr(isaPkg::LDm, 12'h001));
		put(instr(isaPkg::ADm, 12'hfff));
		put(instr(isaPkg::STa, 12'h414));
		probeFlags(12'h430);
		put(instr(isaPkg::LDa, 12'h223));
		put(instr(isaPkg::MLa, 12'h224));
		put(instr(isaPkg::STa, 12'h415));
		probeFlags(12'h434);
		put(instr(isaPkg::LDm, 12'h100));
		put(instr(isaPkg::MLa, 12'h224));
		probeFlags(12'h438);
		endProgram();
		runTest(2);

		// Logic and shift operations
		startProgram();
		progImage[12'h230] = randomWord();
		progImage[12'h231] = randomWord();
		progImage[12'h232] = randomWord() | 16'h8000;
		put(instr(isaPkg::LDa, 12'h230));
		put(instr(isaPkg::ANa, 12'h231));
		put(instr(isaPkg::STa, 12'h440));
		put(extInstr(isaPkg::GROUP2, {isaPkg::ACZ, 5'b0}));
		put(instr(isaPkg::STa, 12'h441));
		probeFlags(12'h450);
		put(instr(isaPkg::LDa, 12'h230));
		put(extInstr(isaPkg::GROUP2, {isaPkg::ACN, 5'b0}));
		put(instr(isaPkg::STa, 12'h442));
		put(extInstr(isaPkg::GROUP2, {isaPkg::ACI, 5'b0}));
		put(instr(isaPkg::STa, 12'h443));
		put(instr(isaPkg::LDa, 12'h231));
		put(extInstr(isaPkg::SRA, 8'd3));
		put(instr(isaPkg::STa, 12'h444));
		put(instr(isaPkg::LDa, 12'h232));
		put(extInstr(isaPkg::SRA, 8'd5));
		put(instr(isaPkg::STa, 12'h445));
		put(extInstr(isaPkg::SRL, 8'd4));
		put(instr(isaPkg::STa, 12'h446));
		put(extInstr(isaPkg::SLL, 8'd7));
		put(instr(isaPkg::STa, 12'h447));
		endProgram();
		runTest(3);

		// Jumps skip the store that follows them
		startProgram();
		put(instr(isaPkg::LDm, 12'h011));
		put(instr(isaPkg::JMa, 12'(progPc + 2)));
		put(instr(isaPkg::STa, 12'h460));
		put(instr(isaPkg::STa, 12'h461));
		progImage[12'h2a0] = 16'(progPc + 3);
		put(instr(isaPkg::JMn, 12'h2a0));
		put(instr(isaPkg::STa, 12'h462));
		put(instr(isaPkg::LDm, 12'h055));
		put(extInstr(isaPkg::GROUP2, {isaPkg::ACI, 5'b0}));
		put(instr(isaPkg::STa, 12'h463));
		endProgram();
		runTest(4);

		@(posedge clk);
		#1;
		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (testsRun == testCount && testsFailed == 0 && errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* files.f */
isaPkg.sv
ctrlPkg.sv
alu.sv
controlUnit.sv
datapath.sv
punehTop.sv
tbChecker.sv
tbTop.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbTop
FILELIST = files.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)
